// ==== compile.f ====
dsp_pkg.sv
block_sequencer.sv
madd_unit.sv
commit_skid.sv
channel_commit.sv
dsp_core.sv
tb_dsp_core_assert.sv
tb_dsp_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dsp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_core \
	-f compile.f -o sim_dsp_core
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_dsp_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1

// ==== tb_dsp_core.sv ====
`timescale 1ns/10ps

module tb_dsp_core;
	typedef struct packed {
		dsp_pkg::channel_addr_t src_a;
		dsp_pkg::channel_addr_t src_b;
		dsp_pkg::channel_addr_t src_c;
		dsp_pkg::channel_addr_t dest;
		dsp_pkg::shift_t shift;
		logic b_reg;
		logic c_reg;
		logic sat_dis;
	} block_def_t;

	typedef struct {
		string name;
		int sample;
		bit reg_write;
		int blk;
		int reg_sel;
		int reg_val;
	} stim_row_t;

	logic clk = 1'b0;
	logic reset;
	logic tick;
	dsp_pkg::sample_t sample_in;
	dsp_pkg::command_t command;
	dsp_pkg::sample_t sample_out;
	logic ready;
	dsp_pkg::block_count_t n_blocks_running;
	logic [31 : 0] commits_accepted;

	int seed = 32'h8137_35aa;
	int ready_timeout = 200;
	int errors = 0;
	int checks = 0;
	int ticks_sent = 0;
	bit timed_out = 1'b0;
	int model_ch [dsp_pkg::n_channels];
	int model_regs [dsp_pkg::n_blocks][2];
	block_def_t prog [3];
	stim_row_t stim_rows [$];

	dsp_core uut (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.command(command),
		.sample_out(sample_out),
		.ready(ready),
		.n_blocks_running(n_blocks_running),
		.commits_accepted(commits_accepted)
	);

	bind dsp_core dsp_core_assert assertions (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.ready(ready),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.skid_valid(skid_valid),
		.skid_ready(skid_ready)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected)
		else begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic next_edge();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_ready(input string name);
		int cycles;
		cycles = 0;
		while (!ready && cycles < ready_timeout) begin
			next_edge();
			cycles++;
		end
		if (!ready) begin
			$display("timeout: ready stayed low for %0d cycles in %s", ready_timeout, name);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic send_command(input dsp_pkg::command_t cmd);
		command = cmd;
		next_edge();
		command = '0;
	endtask

	function automatic dsp_pkg::instr_t encode_instr(input block_def_t def);
		dsp_pkg::instr_t word;
		word = '0;
		word[dsp_pkg::src_a_lsb +: 4] = def.src_a;
		word[dsp_pkg::src_b_lsb +: 4] = def.src_b;
		word[dsp_pkg::src_c_lsb +: 4] = def.src_c;
		word[dsp_pkg::dest_lsb +: 4] = def.dest;
		word[dsp_pkg::shift_lsb +: 5] = def.shift;
		word[dsp_pkg::src_b_reg_bit] = def.b_reg;
		word[dsp_pkg::src_c_reg_bit] = def.c_reg;
		word[dsp_pkg::saturate_disable_bit] = def.sat_dis;
		// junk in the ignored upper byte must not change any result
		word[31 : 24] = 8'ha5;
		return word;
	endfunction

	task automatic load_block(input int blk, input block_def_t def);
		dsp_pkg::command_t cmd;
		cmd = '0;
		cmd.instr_write = 1'b1;
		cmd.block_target = dsp_pkg::block_addr_t'(blk);
		cmd.instr_val = encode_instr(def);
		send_command(cmd);
	endtask

	task automatic load_register(input int blk, input int reg_sel, input int val);
		dsp_pkg::command_t cmd;
		cmd = '0;
		cmd.reg_write = 1'b1;
		cmd.block_target = dsp_pkg::block_addr_t'(blk);
		cmd.reg_target = 1'(reg_sel);
		cmd.reg_val = dsp_pkg::sample_t'(val);
		send_command(cmd);
		model_regs[blk][reg_sel] = val;
	endtask

	// product, arithmetic shift and add, then clamp or keep the low 16 bits
	function automatic int madd_model(input int a, input int b, input int c, input int shift,
		input bit sat_dis);
		longint sum;
		sum = ((longint'(a) * longint'(b)) >>> shift) + longint'(c);
		if (sat_dis)
			return int'($signed(sum[15 : 0]));
		if (sum > 32767)
			return 32767;
		if (sum < -32768)
			return -32768;
		return int'(sum);
	endfunction

	task automatic run_model_pass();
		block_def_t d;
		int b_val;
		int c_val;
		for (int b = 0; b < $size(prog); b++) begin
			d = prog[b];
			b_val = d.b_reg ? model_regs[b][0] : model_ch[d.src_b];
			c_val = d.c_reg ? model_regs[b][1] : model_ch[d.src_c];
			model_ch[d.dest] = madd_model(model_ch[d.src_a], b_val, c_val, int'(d.shift),
				d.sat_dis);
		end
	endtask

	function automatic int random_sample(input int shift);
		dsp_pkg::sample_t raw;
		raw = dsp_pkg::sample_t'($random(seed));
		return int'(raw) >>> shift;
	endfunction

	task automatic add_row(input string name, input int sample, input bit reg_write,
		input int blk, input int reg_sel, input int reg_val);
		stim_rows.push_back(stim_row_t'{name, sample, reg_write, blk, reg_sel, reg_val});
	endtask

	task automatic build_table();
		for (int i = 0; i < 8; i++)
			add_row("chain", random_sample(4), 1'b0, 0, 0, 0);
		// a full gain on block 0 drives the chain into both rails
		add_row("saturate", random_sample(0), 1'b1, 0, 0, 32767);
		for (int i = 0; i < 5; i++)
			add_row("saturate", random_sample(0), 1'b0, 0, 0, 0);
		add_row("wrap", random_sample(0), 1'b1, 1, 0, 30000);
		for (int i = 0; i < 3; i++)
			add_row("wrap", random_sample(0), 1'b0, 0, 0, 0);
		add_row("reg_update", random_sample(4), 1'b1, 0, 0, 256);
		add_row("reg_update", random_sample(4), 1'b1, 1, 0, 8);
		add_row("reg_update", random_sample(4), 1'b1, 2, 1, 1234);
		for (int i = 0; i < 3; i++)
			add_row("reg_update", random_sample(4), 1'b0, 0, 0, 0);
		add_row("reg_update", random_sample(4), 1'b1, 0, 1, -700);
		for (int i = 0; i < 2; i++)
			add_row("reg_update", random_sample(4), 1'b0, 0, 0, 0);
		add_row("flush", 0, 1'b0, 0, 0, 0);
	endtask

	task automatic apply_row(input int index);
		stim_row_t row;
		string name;
		int expected;
		row = stim_rows[index];
		name = $sformatf("%s_%0d", row.name, index);
		wait_ready(name);
		if (timed_out)
			return;
		if (row.reg_write)
			load_register(row.blk, row.reg_sel, row.reg_val);
		// sample_out shows the output channel as it stood before this tick
		expected = model_ch[dsp_pkg::output_channel];
		model_ch[dsp_pkg::input_channel] = row.sample;
		run_model_pass();
		sample_in = dsp_pkg::sample_t'(row.sample);
		tick = 1'b1;
		next_edge();
		tick = 1'b0;
		ticks_sent++;
		wait_ready(name);
		if (timed_out)
			return;
		check_value(name, expected, int'(sample_out));
	endtask

	initial begin
		tick = 1'b0;
		sample_in = '0;
		command = '0;
		reset = 1'b1;
		for (int i = 0; i < dsp_pkg::n_channels; i++)
			model_ch[i] = 0;
		for (int b = 0; b < dsp_pkg::n_blocks; b++) begin
			model_regs[b][0] = 0;
			model_regs[b][1] = 0;
		end
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		check_value("reset_ready", 1, int'(ready));
		check_value("reset_sample_out", 0, int'(sample_out));
		check_value("reset_blocks", 0, int'(n_blocks_running));
		check_value("reset_commits", 0, int'(commits_accepted));

		// blocks 0 and 1 both read the input channel and block 2 joins them into the output
		prog[0] = '{src_a: 4'd1, src_b: 4'd0, src_c: 4'd0, dest: 4'd2, shift: 5'd8,
			b_reg: 1'b1, c_reg: 1'b1, sat_dis: 1'b0};
		prog[1] = '{src_a: 4'd1, src_b: 4'd0, src_c: 4'd1, dest: 4'd3, shift: 5'd4,
			b_reg: 1'b1, c_reg: 1'b0, sat_dis: 1'b1};
		prog[2] = '{src_a: 4'd2, src_b: 4'd3, src_c: 4'd0, dest: 4'd0, shift: 5'd12,
			b_reg: 1'b0, c_reg: 1'b1, sat_dis: 1'b0};
		load_block(0, prog[0]);
		load_block(1, '0);
		load_block(2, prog[2]);
		check_value("blocks_loaded", 3, int'(n_blocks_running));
		load_block(1, prog[1]);
		check_value("block_rewrite", 3, int'(n_blocks_running));

		load_register(0, 0, 256);
		load_register(0, 1, 100);
		load_register(1, 0, 8);
		load_register(2, 1, -50);

		build_table();
		for (int i = 0; i < stim_rows.size() && !timed_out; i++)
			apply_row(i);

		if (!timed_out)
			check_value("commit_count", ticks_sent * $size(prog), int'(commits_accepted));

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb_dsp_core_assert.sv ====
`timescale 1ns/10ps

module dsp_core_assert (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic ready,
	input dsp_pkg::madd_op_t op,
	input logic op_valid,
	input logic op_ready,
	input logic res_valid,
	input logic res_ready,
	input logic skid_valid,
	input logic skid_ready
);
	logic [1 : 0] occupancy;

	// shadow count of the commit skid taken from its input and output handshakes
	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({res_valid && res_ready, skid_valid && skid_ready})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	tick_needs_ready: assert property (@(posedge clk) disable iff (reset) tick |-> ready)
		else $error("tick arrived while the core was busy");

	op_held_stable: assert property (@(posedge clk) disable iff (reset)
		op_valid && !op_ready |=> op_valid && $stable(op))
		else $error("op changed while waiting for op_ready");

	skid_no_overflow: assert property (@(posedge clk) disable iff (reset)
		int'(occupancy) == dsp_pkg::skid_depth |-> !(res_valid && res_ready))
		else $error("commit skid accepted a result while full");

	busy_after_tick: assert property (@(posedge clk) disable iff (reset) tick |=> !ready)
		else $error("ready still high in the cycle after tick");

endmodule

// ==== dsp_core.sv ====
`timescale 1ns/10ps

module dsp_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::sample_t sample_in,
	input dsp_pkg::command_t command,
	output dsp_pkg::sample_t sample_out,
	output logic ready,
	output dsp_pkg::block_count_t n_blocks_running,
	output logic [31 : 0] commits_accepted
);
	dsp_pkg::madd_op_t op;
	logic op_valid;
	logic op_ready;
	dsp_pkg::madd_result_t result;
	logic res_valid;
	logic res_ready;
	dsp_pkg::madd_result_t skid_out;
	logic skid_valid;
	logic skid_ready;
	dsp_pkg::channel_addr_t rd_addr_a;
	dsp_pkg::channel_addr_t rd_addr_b;
	dsp_pkg::channel_addr_t rd_addr_c;
	dsp_pkg::sample_t rd_val_a;
	dsp_pkg::sample_t rd_val_b;
	dsp_pkg::sample_t rd_val_c;
	logic commit;
	dsp_pkg::channel_addr_t commit_dest;

	block_sequencer sequencer (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.command(command),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_addr_c(rd_addr_c),
		.rd_val_a(rd_val_a),
		.rd_val_b(rd_val_b),
		.rd_val_c(rd_val_c),
		.commit(commit),
		.commit_dest(commit_dest),
		.ready(ready),
		.n_blocks_running(n_blocks_running)
	);

	madd_unit madd (
		.clk(clk),
		.reset(reset),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.result(result),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	commit_skid skid (
		.clk(clk),
		.reset(reset),
		.in_data(result),
		.in_valid(res_valid),
		.in_ready(res_ready),
		.out_data(skid_out),
		.out_valid(skid_valid),
		.out_ready(skid_ready)
	);

	channel_commit channel_file (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.in_data(skid_out),
		.in_valid(skid_valid),
		.in_ready(skid_ready),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_addr_c(rd_addr_c),
		.rd_val_a(rd_val_a),
		.rd_val_b(rd_val_b),
		.rd_val_c(rd_val_c),
		.commit(commit),
		.commit_dest(commit_dest),
		.sample_out(sample_out),
		.commits_accepted(commits_accepted)
	);

endmodule

// ==== channel_commit.sv ====
`timescale 1ns/10ps

module channel_commit (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::sample_t sample_in,
	input dsp_pkg::madd_result_t in_data,
	input logic in_valid,
	output logic in_ready,
	input dsp_pkg::channel_addr_t rd_addr_a,
	input dsp_pkg::channel_addr_t rd_addr_b,
	input dsp_pkg::channel_addr_t rd_addr_c,
	output dsp_pkg::sample_t rd_val_a,
	output dsp_pkg::sample_t rd_val_b,
	output dsp_pkg::sample_t rd_val_c,
	output logic commit,
	output dsp_pkg::channel_addr_t commit_dest,
	output dsp_pkg::sample_t sample_out,
	output logic [31 : 0] commits_accepted
);
	dsp_pkg::sample_t channels [dsp_pkg::n_channels];

	// the tick cycle belongs to the sample port and results wait in the skid
	assign in_ready = !tick;
	assign commit = in_valid && in_ready;
	assign commit_dest = in_data.dest;

	assign rd_val_a = channels[rd_addr_a];
	assign rd_val_b = channels[rd_addr_b];
	assign rd_val_c = channels[rd_addr_c];

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_out <= '0;
			commits_accepted <= '0;
			for (int i = 0; i < dsp_pkg::n_channels; i++) begin
				channels[i] <= '0;
			end
		end else begin
			if (tick) begin
				sample_out <= channels[dsp_pkg::output_channel];
				channels[dsp_pkg::input_channel] <= sample_in;
			end
			if (commit) begin
				channels[in_data.dest] <= in_data.value;
				commits_accepted <= commits_accepted + 1'b1;
			end
		end
	end

endmodule

// ==== commit_skid.sv ====
`timescale 1ns/10ps

module commit_skid (
	input logic clk,
	input logic reset,
	input dsp_pkg::madd_result_t in_data,
	input logic in_valid,
	output logic in_ready,
	output dsp_pkg::madd_result_t out_data,
	output logic out_valid,
	input logic out_ready
);
	dsp_pkg::madd_result_t entries [dsp_pkg::skid_depth];
	logic [dsp_pkg::skid_ptr_width - 1 : 0] wr_ptr;
	logic [dsp_pkg::skid_ptr_width - 1 : 0] rd_ptr;
	logic [dsp_pkg::skid_ptr_width : 0] count;
	logic push;
	logic pop;

	assign in_ready = count != dsp_pkg::skid_depth;
	assign out_valid = count != '0;
	assign out_data = entries[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== madd_unit.sv ====
`timescale 1ns/10ps

module madd_unit (
	input logic clk,
	input logic reset,
	input dsp_pkg::madd_op_t op,
	input logic op_valid,
	output logic op_ready,
	output dsp_pkg::madd_result_t result,
	output logic res_valid,
	input logic res_ready
);
	logic s1_valid;
	dsp_pkg::product_t s1_product;
	dsp_pkg::sample_t s1_arg_c;
	dsp_pkg::channel_addr_t s1_dest;
	dsp_pkg::shift_t s1_shift;
	logic s1_sat_disable;
	dsp_pkg::product_t sum;
	dsp_pkg::sample_t clamped;

	// both stages move together and stall as one on back-pressure
	assign op_ready = res_ready;

	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else if (res_ready)
			s1_valid <= op_valid;
	end

	always_ff @(posedge clk) begin
		if (res_ready) begin
			s1_product <= dsp_pkg::product_t'(op.arg_a) * dsp_pkg::product_t'(op.arg_b);
			s1_arg_c <= op.arg_c;
			s1_dest <= op.dest;
			s1_shift <= op.shift;
			s1_sat_disable <= op.saturate_disable;
		end
	end

	always_comb begin
		sum = (s1_product >>> s1_shift) + dsp_pkg::product_t'(s1_arg_c);
		if (s1_sat_disable)
			clamped = dsp_pkg::sample_t'(sum);
		else if (sum > dsp_pkg::sample_max)
			clamped = dsp_pkg::sample_t'(dsp_pkg::sample_max);
		else if (sum < dsp_pkg::sample_min)
			clamped = dsp_pkg::sample_t'(dsp_pkg::sample_min);
		else
			clamped = dsp_pkg::sample_t'(sum);
	end

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else if (res_ready)
			res_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (res_ready) begin
			result.dest <= s1_dest;
			result.value <= clamped;
		end
	end

endmodule

// ==== block_sequencer.sv ====
`timescale 1ns/10ps

module block_sequencer (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::command_t command,
	output dsp_pkg::madd_op_t op,
	output logic op_valid,
	input logic op_ready,
	output dsp_pkg::channel_addr_t rd_addr_a,
	output dsp_pkg::channel_addr_t rd_addr_b,
	output dsp_pkg::channel_addr_t rd_addr_c,
	input dsp_pkg::sample_t rd_val_a,
	input dsp_pkg::sample_t rd_val_b,
	input dsp_pkg::sample_t rd_val_c,
	input logic commit,
	input dsp_pkg::channel_addr_t commit_dest,
	output logic ready,
	output dsp_pkg::block_count_t n_blocks_running
);
	typedef enum logic {
		seq_idle,
		seq_issue
	} seq_state_t;

	seq_state_t state;
	dsp_pkg::instr_t instrs [dsp_pkg::n_blocks];
	dsp_pkg::instr_t instr_q;
	dsp_pkg::sample_t block_regs [dsp_pkg::n_blocks][dsp_pkg::n_block_regs];
	dsp_pkg::block_addr_t cur_block;
	dsp_pkg::block_addr_t fetch_addr;
	dsp_pkg::block_count_t write_count;
	dsp_pkg::channel_addr_t dest;
	logic [dsp_pkg::n_channels - 1 : 0] pending;
	logic b_reg;
	logic c_reg;
	logic hazard;
	logic fire;
	logic last;

	// the store has a registered read, so the next block's address goes out while issuing
	always_comb begin
		if (state == seq_idle)
			fetch_addr = '0;
		else if (fire)
			fetch_addr = cur_block + 1'b1;
		else
			fetch_addr = cur_block;
	end

	always_ff @(posedge clk) begin
		instr_q <= instrs[fetch_addr];
		if (command.instr_write) begin
			instrs[command.block_target] <= command.instr_val;
		end
	end

	assign write_count = dsp_pkg::block_count_t'(command.block_target) + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			n_blocks_running <= '0;
			for (int b = 0; b < dsp_pkg::n_blocks; b++) begin
				for (int r = 0; r < dsp_pkg::n_block_regs; r++) begin
					block_regs[b][r] <= '0;
				end
			end
		end else begin
			if (command.reg_write) begin
				block_regs[command.block_target][command.reg_target] <= command.reg_val;
			end
			// running count follows the highest block written
			if (command.instr_write && write_count >= n_blocks_running) begin
				n_blocks_running <= write_count;
			end
		end
	end

	assign b_reg = instr_q[dsp_pkg::src_b_reg_bit];
	assign c_reg = instr_q[dsp_pkg::src_c_reg_bit];
	assign dest = dsp_pkg::channel_addr_t'(instr_q >> dsp_pkg::dest_lsb);
	assign rd_addr_a = dsp_pkg::channel_addr_t'(instr_q >> dsp_pkg::src_a_lsb);
	assign rd_addr_b = dsp_pkg::channel_addr_t'(instr_q >> dsp_pkg::src_b_lsb);
	assign rd_addr_c = dsp_pkg::channel_addr_t'(instr_q >> dsp_pkg::src_c_lsb);

	// hold while a channel source or the destination still waits for a commit
	assign hazard = pending[rd_addr_a] | (!b_reg & pending[rd_addr_b])
		| (!c_reg & pending[rd_addr_c]) | pending[dest];
	assign op_valid = state == seq_issue && n_blocks_running != '0 && !hazard;
	assign fire = op_valid && op_ready;
	assign last = dsp_pkg::block_count_t'(cur_block) + 1'b1 == n_blocks_running;

	always_comb begin
		op.dest = dest;
		op.arg_a = rd_val_a;
		op.arg_b = b_reg ? block_regs[cur_block][0] : rd_val_b;
		op.arg_c = c_reg ? block_regs[cur_block][1] : rd_val_c;
		op.shift = dsp_pkg::shift_t'(instr_q >> dsp_pkg::shift_lsb);
		op.saturate_disable = instr_q[dsp_pkg::saturate_disable_bit];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_idle;
			cur_block <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (tick) begin
						state <= seq_issue;
						cur_block <= '0;
					end
				end
				seq_issue: begin
					if (n_blocks_running == '0 || (fire && last))
						state <= seq_idle;
					else if (fire)
						cur_block <= cur_block + 1'b1;
				end
				default: state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (commit)
				pending[commit_dest] <= 1'b0;
			if (fire)
				pending[dest] <= 1'b1;
		end
	end

	assign ready = state == seq_idle && pending == '0;

endmodule

// ==== dsp_pkg.sv ====
package dsp_pkg;

	localparam int data_width = 16;
	localparam int n_blocks = 16;
	localparam int n_block_regs = 2;
	localparam int n_channels = 16;
	localparam int skid_depth = 2;
	localparam int skid_ptr_width = $clog2(skid_depth);

	typedef logic signed [data_width - 1 : 0] sample_t;
	typedef logic signed [2 * data_width - 1 : 0] product_t;
	typedef logic [$clog2(n_blocks) - 1 : 0] block_addr_t;
	typedef logic [$clog2(n_blocks) : 0] block_count_t;
	typedef logic [$clog2(n_channels) - 1 : 0] channel_addr_t;
	typedef logic [4 : 0] shift_t;
	typedef logic [31 : 0] instr_t;

	localparam channel_addr_t input_channel = 1;
	localparam channel_addr_t output_channel = 0;

	localparam product_t sample_max = 32'sd32767;
	localparam product_t sample_min = -32'sd32768;

	// lsb positions of the instruction fields below the ignored upper byte
	localparam int src_a_lsb = 0;
	localparam int src_b_lsb = 4;
	localparam int src_c_lsb = 8;
	localparam int dest_lsb = 12;
	localparam int shift_lsb = 16;
	localparam int src_b_reg_bit = 21;
	localparam int src_c_reg_bit = 22;
	localparam int saturate_disable_bit = 23;

	typedef struct packed {
		logic instr_write;
		logic reg_write;
		block_addr_t block_target;
		logic reg_target;
		instr_t instr_val;
		sample_t reg_val;
	} command_t;

	typedef struct packed {
		channel_addr_t dest;
		sample_t arg_a;
		sample_t arg_b;
		sample_t arg_c;
		shift_t shift;
		logic saturate_disable;
	} madd_op_t;

	typedef struct packed {
		channel_addr_t dest;
		sample_t value;
	} madd_result_t;

endpackage
